// File: Bender.yml
package:
  name: vliw_datapath

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/vliw_pkg.sv
      - rtl/result_bank.sv
      - rtl/operand_fetch.sv
      - rtl/fp_adder.sv
      - rtl/writeback_ctrl.sv
      - rtl/vliw_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - testbench/vliw_tb.sv

// File: rtl/fp_adder.sv
`timescale 1ns/100ps
`default_nettype none

`include "vliw_defs.svh"

module fp_adder (
   input  wire                        clk,
   input  wire                        reset,
   input  wire vliw_pkg::fp_word_t    a,
   input  wire vliw_pkg::fp_word_t    b,
   output vliw_pkg::fp_word_t         sum
);

   localparam int SIG_W   = `VLIW_MAN_W + 1;
   localparam int SUM_W   = `VLIW_MAN_W + 2;
   localparam int LEAD_W  = $clog2(SUM_W);
   localparam int EXP_MAX = (1 << `VLIW_EXP_W) - 1;

   // ========================================
   // Stage 1 orders, aligns and adds
   // ========================================

   vliw_pkg::fp_word_t     big_op;
   vliw_pkg::fp_word_t     small_op;
   logic [`VLIW_EXP_W-1:0] exp_diff;
   logic [SIG_W-1:0]       big_sig;
   logic [SIG_W-1:0]       small_sig;
   logic [SUM_W-1:0]       raw_sum;

   logic                   s1_sign;
   logic [`VLIW_EXP_W-1:0] s1_exp;
   logic [SUM_W-1:0]       s1_sum;

   always_comb begin
      if ({a.exponent, a.mantissa} >= {b.exponent, b.mantissa}) begin
         big_op   = a;
         small_op = b;
      end else begin
         big_op   = b;
         small_op = a;
      end
      exp_diff = big_op.exponent - small_op.exponent;
      // Zero has no hidden one, so it adds nothing
      big_sig   = {|big_op.exponent, big_op.mantissa};
      small_sig = {|small_op.exponent, small_op.mantissa} >> exp_diff;
      if (big_op.sign == small_op.sign) begin
         raw_sum = big_sig + small_sig;
      end else begin
         raw_sum = big_sig - small_sig;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         s1_sign <= 1'b0;
         s1_exp  <= '0;
         s1_sum  <= '0;
      end else begin
         s1_sign <= big_op.sign;
         s1_exp  <= big_op.exponent;
         s1_sum  <= raw_sum;
      end
   end

   // ========================================
   // Stage 2 normalizes
   // ========================================

   logic [LEAD_W-1:0] lead;
   logic [SUM_W-1:0]  shifted;
   int                exp_norm;

   always_comb begin
      lead = '0;
      for (int i = 0; i < SUM_W; i++) begin
         if (s1_sum[i]) begin
            lead = LEAD_W'(i);
         end
      end
      // Leading one moves to the top bit
      shifted  = s1_sum << (SUM_W - 1 - lead);
      exp_norm = int'(s1_exp) + int'(lead) - (SIG_W - 1);

      sum = '0;
      if (s1_sum != '0 && exp_norm > 0) begin
         sum.sign = s1_sign;
         if (exp_norm > EXP_MAX) begin
            // Clamp to largest finite value
            sum.exponent = '1;
            sum.mantissa = '1;
         end else begin
            sum.exponent = exp_norm[`VLIW_EXP_W-1:0];
            sum.mantissa = shifted[SUM_W-2 -: `VLIW_MAN_W];
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/operand_fetch.sv
`timescale 1ns/100ps
`default_nettype none

`include "vliw_defs.svh"

module operand_fetch (
   input  wire vliw_pkg::opnd_addr_t  addr,
   input  wire vliw_pkg::fp_word_t    z_value,
   input  wire vliw_pkg::fp_word_t    load_data,
   input  wire vliw_pkg::fp_word_t    neg_data,
   input  wire vliw_pkg::fp_word_t    add_data,
   output vliw_pkg::fp_word_t         operand
);

   always_comb begin
      if (addr.index == `VLIW_Z_INDEX) begin
         // Slot 0 of any bank aliases z
         operand = z_value;
      end else begin
         case (addr.bank)
            `VLIW_BANK_LOAD: operand = load_data;
            `VLIW_BANK_NEG:  operand = neg_data;
            `VLIW_BANK_ADD:  operand = add_data;
            // No producer behind code 3
            default:         operand = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: rtl/result_bank.sv
`timescale 1ns/100ps
`default_nettype none

`include "vliw_defs.svh"

module result_bank (
   input  wire                           clk,
   input  wire vliw_pkg::bank_write_t    wr,
   input  wire [`VLIW_INDEX_W-1:0]       rd_index_neg,
   input  wire [`VLIW_INDEX_W-1:0]       rd_index_add1,
   input  wire [`VLIW_INDEX_W-1:0]       rd_index_add2,
   output vliw_pkg::fp_word_t            rd_data_neg,
   output vliw_pkg::fp_word_t            rd_data_add1,
   output vliw_pkg::fp_word_t            rd_data_add2
);

   localparam int DEPTH = 1 << `VLIW_INDEX_W;

   vliw_pkg::fp_word_t mem [DEPTH];

   // Single write port owned by this bank's producer
   always_ff @(posedge clk) begin
      if (wr.enable) begin
         mem[wr.index] <= wr.data;
      end
   end

   // Asynchronous reads, one per consuming operand
   assign rd_data_neg  = mem[rd_index_neg];
   assign rd_data_add1 = mem[rd_index_add1];
   assign rd_data_add2 = mem[rd_index_add2];

endmodule

`default_nettype wire

// File: rtl/vliw_defs.svh
`ifndef VLIW_DEFS_SVH
`define VLIW_DEFS_SVH

// Floating-point word layout
`define VLIW_WORD_W    27
`define VLIW_EXP_W     8
`define VLIW_MAN_W     18
`define VLIW_EXP_BIAS  127

// Operand addressing
`define VLIW_INDEX_W   8
`define VLIW_BANK_W    2

// Index that reads and writes the z register in every bank
`define VLIW_Z_INDEX   0

// Producer bank codes
`define VLIW_BANK_LOAD 2'd0
`define VLIW_BANK_NEG  2'd1
`define VLIW_BANK_ADD  2'd2

`endif

// File: rtl/vliw_pkg.sv
`default_nettype none

package vliw_pkg;

`include "vliw_defs.svh"

   // ========================================
   // Data and addresses
   // ========================================

   typedef struct packed {
      logic                    sign;
      logic [`VLIW_EXP_W-1:0]  exponent;
      logic [`VLIW_MAN_W-1:0]  mantissa;
   } fp_word_t;

   // Upper bits pick the producer bank, lower bits the slot
   typedef struct packed {
      logic [`VLIW_BANK_W-1:0]  bank;
      logic [`VLIW_INDEX_W-1:0] index;
   } opnd_addr_t;

   // ========================================
   // Issue slots and bank writes
   // ========================================

   typedef struct packed {
      logic       enable;
      fp_word_t   value;
      opnd_addr_t dest;
   } load_issue_t;

   typedef struct packed {
      logic       enable;
      opnd_addr_t src;
      opnd_addr_t dest;
   } neg_issue_t;

   typedef struct packed {
      logic       enable;
      opnd_addr_t src1;
      opnd_addr_t src2;
      opnd_addr_t dest;
   } add_issue_t;

   typedef struct packed {
      logic                     enable;
      logic [`VLIW_INDEX_W-1:0] index;
      fp_word_t                 data;
   } bank_write_t;

endpackage

`default_nettype wire

// File: rtl/vliw_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "vliw_defs.svh"

module vliw_top (
   input  wire                        clk,
   input  wire                        reset,
   input  wire vliw_pkg::load_issue_t load_issue,
   input  wire vliw_pkg::neg_issue_t  neg_issue,
   input  wire vliw_pkg::add_issue_t  add_issue,
   output vliw_pkg::fp_word_t         z_value
);

   vliw_pkg::bank_write_t load_wr;
   vliw_pkg::bank_write_t neg_wr;
   vliw_pkg::bank_write_t add_wr;

   // Bank read data by bank and consumer
   vliw_pkg::fp_word_t load_rd_neg, load_rd_add1, load_rd_add2;
   vliw_pkg::fp_word_t neg_rd_neg, neg_rd_add1, neg_rd_add2;
   vliw_pkg::fp_word_t add_rd_neg, add_rd_add1, add_rd_add2;

   vliw_pkg::fp_word_t neg_opnd;
   vliw_pkg::fp_word_t neg_result;
   vliw_pkg::fp_word_t add_opnd1;
   vliw_pkg::fp_word_t add_opnd2;
   vliw_pkg::fp_word_t add_result;

   // ========================================
   // Result banks
   // ========================================

   result_bank load_bank (
      .clk(clk), .wr(load_wr),
      .rd_index_neg(neg_issue.src.index), .rd_index_add1(add_issue.src1.index),
      .rd_index_add2(add_issue.src2.index),
      .rd_data_neg(load_rd_neg), .rd_data_add1(load_rd_add1), .rd_data_add2(load_rd_add2)
   );

   result_bank neg_bank (
      .clk(clk), .wr(neg_wr),
      .rd_index_neg(neg_issue.src.index), .rd_index_add1(add_issue.src1.index),
      .rd_index_add2(add_issue.src2.index),
      .rd_data_neg(neg_rd_neg), .rd_data_add1(neg_rd_add1), .rd_data_add2(neg_rd_add2)
   );

   result_bank add_bank (
      .clk(clk), .wr(add_wr),
      .rd_index_neg(neg_issue.src.index), .rd_index_add1(add_issue.src1.index),
      .rd_index_add2(add_issue.src2.index),
      .rd_data_neg(add_rd_neg), .rd_data_add1(add_rd_add1), .rd_data_add2(add_rd_add2)
   );

   // ========================================
   // Operand fetch and pipes
   // ========================================

   operand_fetch neg_fetch (
      .addr(neg_issue.src), .z_value(z_value), .load_data(load_rd_neg),
      .neg_data(neg_rd_neg), .add_data(add_rd_neg), .operand(neg_opnd)
   );

   operand_fetch add1_fetch (
      .addr(add_issue.src1), .z_value(z_value), .load_data(load_rd_add1),
      .neg_data(neg_rd_add1), .add_data(add_rd_add1), .operand(add_opnd1)
   );

   operand_fetch add2_fetch (
      .addr(add_issue.src2), .z_value(z_value), .load_data(load_rd_add2),
      .neg_data(neg_rd_add2), .add_data(add_rd_add2), .operand(add_opnd2)
   );

   // Negate flips the sign and keeps zero all-zero
   always_comb begin
      if (neg_opnd.exponent == '0) begin
         neg_result = `VLIW_WORD_W'(0);
      end else begin
         neg_result      = neg_opnd;
         neg_result.sign = ~neg_opnd.sign;
      end
   end

   fp_adder adder (
      .clk(clk), .reset(reset), .a(add_opnd1), .b(add_opnd2), .sum(add_result)
   );

   writeback_ctrl writeback (
      .clk(clk), .reset(reset),
      .load_issue(load_issue), .neg_issue(neg_issue), .neg_data(neg_result),
      .add_issue(add_issue), .add_data(add_result),
      .load_wr(load_wr), .neg_wr(neg_wr), .add_wr(add_wr), .z_value(z_value)
   );

endmodule

`default_nettype wire

// File: rtl/writeback_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "vliw_defs.svh"

module writeback_ctrl (
   input  wire                        clk,
   input  wire                        reset,
   input  wire vliw_pkg::load_issue_t load_issue,
   input  wire vliw_pkg::neg_issue_t  neg_issue,
   input  wire vliw_pkg::fp_word_t    neg_data,
   input  wire vliw_pkg::add_issue_t  add_issue,
   input  wire vliw_pkg::fp_word_t    add_data,
   output vliw_pkg::bank_write_t      load_wr,
   output vliw_pkg::bank_write_t      neg_wr,
   output vliw_pkg::bank_write_t      add_wr,
   output vliw_pkg::fp_word_t         z_value
);

   logic                 add_dly_en;
   vliw_pkg::opnd_addr_t add_dly_dest;

   // Add result lands one cycle after issue
   always_ff @(posedge clk) begin
      if (reset) begin
         add_dly_en <= 1'b0;
      end else begin
         add_dly_en <= add_issue.enable;
      end
   end

   always_ff @(posedge clk) begin
      add_dly_dest <= add_issue.dest;
   end

   // ========================================
   // Bank write ports
   // ========================================

   always_comb begin
      load_wr.enable = load_issue.enable && (load_issue.dest.bank == `VLIW_BANK_LOAD);
      load_wr.index  = load_issue.dest.index;
      load_wr.data   = load_issue.value;

      neg_wr.enable  = neg_issue.enable && (neg_issue.dest.bank == `VLIW_BANK_NEG);
      neg_wr.index   = neg_issue.dest.index;
      neg_wr.data    = neg_data;

      add_wr.enable  = add_dly_en && (add_dly_dest.bank == `VLIW_BANK_ADD);
      add_wr.index   = add_dly_dest.index;
      add_wr.data    = add_data;
   end

   // Z register with load over negate over add
   always_ff @(posedge clk) begin
      if (reset) begin
         z_value <= '0;
      end else if (load_issue.enable && load_issue.dest.index == `VLIW_Z_INDEX) begin
         z_value <= load_issue.value;
      end else if (neg_issue.enable && neg_issue.dest.index == `VLIW_Z_INDEX) begin
         z_value <= neg_data;
      end else if (add_dly_en && add_dly_dest.index == `VLIW_Z_INDEX) begin
         z_value <= add_data;
      end
   end

endmodule

`default_nettype wire

// File: sources.f
+incdir+rtl
rtl/vliw_pkg.sv
rtl/result_bank.sv
rtl/operand_fetch.sv
rtl/fp_adder.sv
rtl/writeback_ctrl.sv
rtl/vliw_top.sv
testbench/vliw_tb.sv

// File: testbench/vliw_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "vliw_defs.svh"

module vliw_tb;

   localparam int CLK_PERIOD = 8;
   localparam int NUM_TESTS  = 5;
   localparam vliw_pkg::fp_word_t ZERO_WORD = '0;

   logic                  clk;
   logic                  reset;
   vliw_pkg::load_issue_t load_issue;
   vliw_pkg::neg_issue_t  neg_issue;
   vliw_pkg::add_issue_t  add_issue;
   vliw_pkg::fp_word_t    z_value;

   vliw_pkg::fp_word_t    p1_5, n1_5, p2_25, p3_75, p3_0;
   logic [`VLIW_INDEX_W-1:0] ia, ib, ic;

   vliw_top UUT (
      .clk(clk), .reset(reset), .load_issue(load_issue), .neg_issue(neg_issue),
      .add_issue(add_issue), .z_value(z_value)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ========================================
   // Helpers
   // ========================================

   // Value = (-1)^sign * 1.frac * 2^pow2
   function automatic vliw_pkg::fp_word_t make_fp(input logic sign, input int pow2,
                                                  input logic [`VLIW_MAN_W-1:0] frac);
      vliw_pkg::fp_word_t w;
      w.sign     = sign;
      w.exponent = `VLIW_EXP_W'(pow2 + `VLIW_EXP_BIAS);
      w.mantissa = frac;
      return w;
   endfunction

   function automatic vliw_pkg::opnd_addr_t mk_addr(input logic [`VLIW_BANK_W-1:0] bank,
                                                    input logic [`VLIW_INDEX_W-1:0] index);
      vliw_pkg::opnd_addr_t a;
      a.bank  = bank;
      a.index = index;
      return a;
   endfunction

   // Nonzero slot from 1 to 255
   function automatic logic [`VLIW_INDEX_W-1:0] rand_index();
      return `VLIW_INDEX_W'(1 + ($urandom % 255));
   endfunction

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic clear_issues();
      load_issue = '0;
      neg_issue  = '0;
      add_issue  = '0;
   endtask

   task automatic check_word(input vliw_pkg::fp_word_t expected, input string what);
      if (z_value !== expected) begin
         $display("ERR %0t: %s, z_value %h expected %h", $time, what, z_value, expected);
         $display("Test failures found");
         $fatal;
      end
   endtask

   task automatic set_load(input vliw_pkg::fp_word_t v, input vliw_pkg::opnd_addr_t dest);
      load_issue.enable = 1'b1;
      load_issue.value  = v;
      load_issue.dest   = dest;
   endtask

   task automatic set_neg(input vliw_pkg::opnd_addr_t src, input vliw_pkg::opnd_addr_t dest);
      neg_issue.enable = 1'b1;
      neg_issue.src    = src;
      neg_issue.dest   = dest;
   endtask

   task automatic set_add(input vliw_pkg::opnd_addr_t src1, input vliw_pkg::opnd_addr_t src2,
                          input vliw_pkg::opnd_addr_t dest);
      add_issue.enable = 1'b1;
      add_issue.src1   = src1;
      add_issue.src2   = src2;
      add_issue.dest   = dest;
   endtask

   // ========================================
   // Tests
   // ========================================

   task automatic reset_and_load_test();
      check_word(ZERO_WORD, "z after reset");
      set_load(p1_5, mk_addr(`VLIW_BANK_LOAD, 0));
      step();
      clear_issues();
      check_word(p1_5, "direct load to z");
   endtask

   task automatic load_negate_test();
      set_load(p2_25, mk_addr(`VLIW_BANK_LOAD, ia));
      step();
      clear_issues();
      set_neg(mk_addr(`VLIW_BANK_LOAD, ia), mk_addr(`VLIW_BANK_LOAD, 0));
      step();
      clear_issues();
      check_word({~p2_25.sign, p2_25.exponent, p2_25.mantissa}, "negate from load bank");
   endtask

   task automatic negate_round_trip_test();
      set_neg(mk_addr(`VLIW_BANK_LOAD, ia), mk_addr(`VLIW_BANK_NEG, ib));
      step();
      clear_issues();
      set_neg(mk_addr(`VLIW_BANK_NEG, ib), mk_addr(`VLIW_BANK_NEG, 0));
      step();
      clear_issues();
      check_word(p2_25, "double negate");
      // Bank code 3 has no producer
      set_neg(mk_addr(2'd3, ic), mk_addr(`VLIW_BANK_NEG, 0));
      step();
      clear_issues();
      check_word(ZERO_WORD, "negate from bank 3");
   endtask

   task automatic add_test();
      set_load(p1_5, mk_addr(`VLIW_BANK_LOAD, ia));
      step();
      set_load(p2_25, mk_addr(`VLIW_BANK_LOAD, ib));
      step();
      set_load(n1_5, mk_addr(`VLIW_BANK_LOAD, ic));
      step();
      set_load(ZERO_WORD, mk_addr(`VLIW_BANK_LOAD, 0));
      step();
      clear_issues();
      set_add(mk_addr(`VLIW_BANK_LOAD, ia), mk_addr(`VLIW_BANK_LOAD, ib),
              mk_addr(`VLIW_BANK_ADD, 0));
      step();
      clear_issues();
      check_word(ZERO_WORD, "add not yet written");
      step();
      check_word(p3_75, "1.5 + 2.25");
      set_add(mk_addr(`VLIW_BANK_LOAD, ia), mk_addr(`VLIW_BANK_LOAD, ic),
              mk_addr(`VLIW_BANK_ADD, 0));
      step();
      clear_issues();
      step();
      check_word(ZERO_WORD, "1.5 + -1.5");
      // Two adds in flight at once
      set_add(mk_addr(`VLIW_BANK_LOAD, ia), mk_addr(`VLIW_BANK_LOAD, ib),
              mk_addr(`VLIW_BANK_ADD, ib));
      step();
      set_add(mk_addr(`VLIW_BANK_LOAD, ia), mk_addr(`VLIW_BANK_LOAD, ia),
              mk_addr(`VLIW_BANK_ADD, ic));
      step();
      clear_issues();
      step();
      set_neg(mk_addr(`VLIW_BANK_ADD, ib), mk_addr(`VLIW_BANK_ADD, 0));
      step();
      check_word({1'b1, p3_75[`VLIW_WORD_W-2:0]}, "first back-to-back add");
      set_neg(mk_addr(`VLIW_BANK_ADD, ic), mk_addr(`VLIW_BANK_ADD, 0));
      step();
      clear_issues();
      check_word({1'b1, p3_0[`VLIW_WORD_W-2:0]}, "second back-to-back add");
   endtask

   task automatic z_priority_test();
      set_load(p3_0, mk_addr(`VLIW_BANK_LOAD, 0));
      set_neg(mk_addr(`VLIW_BANK_LOAD, ib), mk_addr(`VLIW_BANK_LOAD, 0));
      step();
      clear_issues();
      check_word(p3_0, "load beats negate");
      set_add(mk_addr(`VLIW_BANK_LOAD, ia), mk_addr(`VLIW_BANK_LOAD, ib),
              mk_addr(`VLIW_BANK_ADD, 0));
      step();
      clear_issues();
      set_neg(mk_addr(`VLIW_BANK_LOAD, ia), mk_addr(`VLIW_BANK_LOAD, 0));
      step();
      clear_issues();
      check_word(n1_5, "negate beats delayed add");
   endtask

   // Watchdog allows 200 cycles per test
   initial begin
      #(NUM_TESTS * 200 * CLK_PERIOD);
      $display("Timeout: the tests did not finish in the allowed time");
      $display("Test failures found");
      $fatal;
   end

   initial begin
      void'($urandom(32'h1c76));
      reset = 1'b1;
      clear_issues();
      p1_5  = make_fp(1'b0, 0, 18'h20000);
      n1_5  = make_fp(1'b1, 0, 18'h20000);
      p2_25 = make_fp(1'b0, 1, 18'h08000);
      p3_75 = make_fp(1'b0, 1, 18'h38000);
      p3_0  = make_fp(1'b0, 1, 18'h20000);
      // Three distinct nonzero slots
      ia = rand_index();
      ib = (ia % 255) + 1;
      ic = (ib % 255) + 1;
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;
      reset_and_load_test();
      load_negate_test();
      negate_round_trip_test();
      add_test();
      z_priority_test();
      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire
